//--- verilog/uart_pkg.sv
package uart_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  typedef logic [7:0]  char_t;      // One transmit character
  typedef logic [15:0] divisor_t;   // Clock cycles per bit
  typedef logic [2:0]  reg_addr_t;  // Register port address

  // Register map
  localparam reg_addr_t ADDR_THR = 3'd0;
  localparam reg_addr_t ADDR_FCR = 3'd2;
  localparam reg_addr_t ADDR_LCR = 3'd3;
  localparam reg_addr_t ADDR_LSR = 3'd5;
  localparam reg_addr_t ADDR_DLL = 3'd6;  // Own address, no DLAB
  localparam reg_addr_t ADDR_DLM = 3'd7;

  ////////////////////
  // Register layouts
  ////////////////////

  // Line control, MSB first
  typedef struct packed {
    logic       unused;
    logic       set_break;   // Hold line low
    logic [1:0] par_sel;     // 00 odd, 01 even, 10 forced 1, 11 forced 0
    logic       par_en;
    logic       stop_bits;   // 0 one stop, 1 two stop
    logic [1:0] word_len;    // 0..3 means 5..8 bits
  } lcr_t;

  // FIFO control
  typedef struct packed {
    logic [4:0] rsvd_hi;
    logic       tx_fifo_rst;  // Self clearing
    logic       rsvd_lo;
    logic       fifo_en;
  } fcr_t;

  // Line status, only the transmit bits
  typedef struct packed {
    logic       rsvd_7;
    logic       tx_empty;    // Nothing queued and FSM idle
    logic       thr_empty;   // Holding register and FIFO empty
    logic [4:0] rsvd_lo;
  } lsr_t;

  localparam lcr_t LCR_RESET = 8'h03;  // 8N1
  localparam lsr_t LSR_RESET = 8'h60;  // Both empty flags set

  ////////////////////
  // Block interfaces
  ////////////////////

  // Register file to transmitter
  typedef struct packed {
    char_t thr;
    logic  thr_write;  // Single cycle strobe
    fcr_t  fcr;
    lcr_t  lcr;
  } reg_read_t;

  // Transmitter back to register file
  typedef struct packed {
    logic [1:0] lsr_valid;        // [0] thr_empty, [1] tx_empty
    logic       lsr_thr_empty;
    logic       lsr_tx_empty;
    logic       fcr_tx_valid;
    logic       fcr_tx_fifo_rst;
  } tx_reg_write_t;

  // Frame FSM
  typedef enum logic [2:0] {
    TXIDLE,
    TXSTART,
    TXDATA,
    TXPAR,
    TXSTOP1,
    TXSTOP2,
    TXFINISH
  } state_type_tx;

endpackage

//--- verilog/uart_baud_gen.sv
module uart_baud_gen (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  uart_pkg::divisor_t divisor_i,
  output logic               baud_rate_o,
  output logic               double_baud_rate_o
);

  import uart_pkg::*;

  divisor_t div_q;       // Divisor the counters run on
  divisor_t bit_cnt_q;   // Bit period down-counter
  divisor_t half_cnt_q;  // Half-bit down-counter
  divisor_t bit_last;
  divisor_t half_val;
  divisor_t half_last;
  logic     short_div;   // Divisor 0 or 1
  logic     div_change;
  logic     baud_q;
  logic     dbl_q;

  assign short_div  = (divisor_i < 16'd2);
  assign bit_last   = short_div ? '0 : divisor_i - 16'd1;
  assign half_val   = short_div ? 16'd1 : (divisor_i >> 1);  // Floor, at least 1
  assign half_last  = half_val - 16'd1;
  assign div_change = (divisor_i != div_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q      <= 16'd1;  // Matches divisor reset value
      bit_cnt_q  <= '0;
      half_cnt_q <= '0;
      baud_q     <= 1'b0;
      dbl_q      <= 1'b0;
    end else if (div_change) begin
      // Restart both counters in phase
      div_q      <= divisor_i;
      bit_cnt_q  <= bit_last;
      half_cnt_q <= half_last;
      baud_q     <= 1'b0;
      dbl_q      <= 1'b0;
    end else begin
      if (bit_cnt_q == '0) begin
        bit_cnt_q <= bit_last;
        baud_q    <= short_div ? ~baud_q : 1'b1;  // Rising edge once per period
      end else begin
        bit_cnt_q <= bit_cnt_q - 16'd1;
        if (bit_cnt_q == half_val) baud_q <= 1'b0;  // Mid period fall
      end
      // Half-bit pulse, lines up with the rising edge
      half_cnt_q <= (half_cnt_q == '0) ? half_last : half_cnt_q - 16'd1;
      dbl_q      <= (half_cnt_q == '0);
    end
  end

  assign baud_rate_o        = baud_q;
  assign double_baud_rate_o = dbl_q;

endmodule

//--- verilog/uart_regs.sv
module uart_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    reg_we_i,
  input  uart_pkg::reg_addr_t     reg_addr_i,
  input  uart_pkg::char_t         reg_wdata_i,
  output uart_pkg::char_t         reg_rdata_o,
  input  uart_pkg::tx_reg_write_t reg_write_i,
  output uart_pkg::reg_read_t     reg_read_o,
  output uart_pkg::divisor_t      divisor_o
);

  import uart_pkg::*;

  char_t    thr_q;      // Holding register contents
  fcr_t     fcr_q;
  lcr_t     lcr_q;
  lsr_t     lsr_q;
  divisor_t divisor_q;  // {DLM, DLL}
  logic     thr_write;

  ////////////////////
  // Write decode
  ////////////////////

  assign thr_write = reg_we_i && (reg_addr_i == ADDR_THR);

  // Character data
  always_ff @(posedge clk_i) begin
    if (thr_write) thr_q <= reg_wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fcr_q     <= '0;
      lcr_q     <= LCR_RESET;
      divisor_q <= 16'd1;
    end else begin
      if (reg_we_i) begin
        case (reg_addr_i)
          ADDR_FCR: begin
            fcr_q.fifo_en     <= reg_wdata_i[0];
            fcr_q.tx_fifo_rst <= reg_wdata_i[2];  // Reserved bits stay zero
          end
          ADDR_LCR: lcr_q <= reg_wdata_i;
          ADDR_DLL: divisor_q[7:0]  <= reg_wdata_i;
          ADDR_DLM: divisor_q[15:8] <= reg_wdata_i;
          default: ;
        endcase
      end
      // Transmitter clears the FIFO reset bit, over software
      if (reg_write_i.fcr_tx_valid) begin
        fcr_q.tx_fifo_rst <= reg_write_i.fcr_tx_fifo_rst;
      end
    end
  end

  ////////////////////
  // Line status
  ////////////////////

  // Only the flagged bits change
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lsr_q <= LSR_RESET;
    end else begin
      if (reg_write_i.lsr_valid[0]) lsr_q.thr_empty <= reg_write_i.lsr_thr_empty;
      if (reg_write_i.lsr_valid[1]) lsr_q.tx_empty  <= reg_write_i.lsr_tx_empty;
    end
  end

  ////////////////////
  // Read back
  ////////////////////

  always_comb begin
    case (reg_addr_i)
      ADDR_FCR: reg_rdata_o = fcr_q;
      ADDR_LCR: reg_rdata_o = lcr_q;
      ADDR_LSR: reg_rdata_o = lsr_q;
      ADDR_DLL: reg_rdata_o = divisor_q[7:0];
      ADDR_DLM: reg_rdata_o = divisor_q[15:8];
      default:  reg_rdata_o = '0;  // THR is write only, no receiver
    endcase
  end

  // Snapshot for the transmitter
  always_comb begin
    reg_read_o           = '0;
    reg_read_o.thr       = thr_q;
    reg_read_o.thr_write = thr_write;  // Same cycle as the write
    reg_read_o.fcr       = fcr_q;
    reg_read_o.lcr       = lcr_q;
  end

  assign divisor_o = divisor_q;

endmodule

//--- verilog/uart_tx_fifo.sv
module uart_tx_fifo #(
  parameter int unsigned DEPTH = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  uart_pkg::char_t          data_i,
  input  logic                     pop_i,
  output uart_pkg::char_t          data_o,
  output logic                     full_o,
  output logic                     empty_o,
  output logic [$clog2(DEPTH):0]   usage_o
);

  import uart_pkg::*;

  localparam int unsigned   AW       = $clog2(DEPTH);
  localparam logic [AW-1:0] LAST     = AW'(DEPTH - 1);    // Pointer wrap point
  localparam logic [AW:0]   FULL_CNT = (AW + 1)'(DEPTH);

  char_t         mem_q [DEPTH];  // Storage
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count_q == FULL_CNT);
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];  // Head word, no fall-through

  assign do_push = push_i && !full_o && !flush_i;  // Flush wins
  assign do_pop  = pop_i && !empty_o && !flush_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // Both or none
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- verilog/uart_tx.sv
module uart_tx #(
  parameter int unsigned TX_FIFO_DEPTH = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    baud_rate_i,
  input  logic                    double_baud_rate_i,
  input  uart_pkg::reg_read_t     reg_read_i,
  output uart_pkg::tx_reg_write_t reg_write_o,
  output logic                    txd_o
);

  import uart_pkg::*;

  // Baud edge
  logic baud_q;
  logic baud_edge;

  // FIFO side
  logic  fifo_mode;
  logic  fifo_flush;
  logic  fifo_push;
  logic  fifo_pop;
  logic  fifo_full;
  logic  fifo_empty;
  char_t fifo_data;

  // Holding register and status
  logic thr_full_q, thr_full_d;
  logic thr_load;     // FSM takes THR directly
  logic thr_idle, thr_idle_q;
  logic tx_idle, tx_idle_q;

  // Frame FSM
  state_type_tx state_q, state_d;
  char_t        tsr_q, tsr_d;
  logic [2:0]   bit_cnt_q, bit_cnt_d;
  logic [2:0]   last_bit;
  char_t        word_mask;
  char_t        load_char;
  logic         par_bit;
  logic         txd_q, txd_d;

  ////////////////////
  // Baud edge detect
  ////////////////////

  assign baud_edge = baud_rate_i & ~baud_q;  // High one cycle per bit

  ////////////////////
  // Transmit FIFO
  ////////////////////

  assign fifo_mode  = reg_read_i.fcr.fifo_en;
  assign fifo_flush = ~fifo_mode | reg_read_i.fcr.tx_fifo_rst;  // Held clear when off
  assign fifo_push  = thr_full_q & ~fifo_full & ~fifo_flush;

  uart_tx_fifo #(
    .DEPTH (TX_FIFO_DEPTH)
  ) i_tx_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (fifo_flush),
    .push_i  (fifo_push),
    .data_i  (reg_read_i.thr),
    .pop_i   (fifo_pop),
    .data_o  (fifo_data),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .usage_o ()
  );

  // Holding register flag, one driver
  always_comb begin
    thr_full_d = thr_full_q;
    if (fifo_push || thr_load) thr_full_d = 1'b0;
    if (reg_read_i.thr_write)  thr_full_d = 1'b1;  // New write wins, overwrites
  end

  ////////////////////
  // Status back to regs
  ////////////////////

  assign thr_idle = ~thr_full_q & fifo_empty;
  assign tx_idle  = thr_idle & (state_q == TXIDLE);

  always_comb begin
    reg_write_o = '0;
    // Set on the rising status only
    reg_write_o.lsr_valid     = {tx_idle & ~tx_idle_q, thr_idle & ~thr_idle_q};
    reg_write_o.lsr_thr_empty = 1'b1;
    reg_write_o.lsr_tx_empty  = 1'b1;
    if (reg_read_i.thr_write) begin
      reg_write_o.lsr_valid     = 2'b11;  // Clear both on a write
      reg_write_o.lsr_thr_empty = 1'b0;
      reg_write_o.lsr_tx_empty  = 1'b0;
    end
    reg_write_o.fcr_tx_valid    = reg_read_i.fcr.tx_fifo_rst;  // Self clear after one flush
    reg_write_o.fcr_tx_fifo_rst = 1'b0;
  end

  ////////////////////
  // Frame FSM
  ////////////////////

  assign last_bit  = {1'b1, reg_read_i.lcr.word_len};  // Index of last data bit
  assign word_mask = char_t'(8'hFF >> (2'd3 - reg_read_i.lcr.word_len));
  assign load_char = (fifo_mode ? fifo_data : reg_read_i.thr) & word_mask;

  always_comb begin
    case (reg_read_i.lcr.par_sel)
      2'b00:   par_bit = ~^tsr_q;  // Odd
      2'b01:   par_bit = ^tsr_q;   // Even
      2'b10:   par_bit = 1'b1;
      default: par_bit = 1'b0;
    endcase
  end

  always_comb begin
    state_d   = state_q;
    tsr_d     = tsr_q;
    bit_cnt_d = bit_cnt_q;
    txd_d     = txd_q;
    fifo_pop  = 1'b0;
    thr_load  = 1'b0;
    case (state_q)
      TXIDLE: begin
        txd_d     = 1'b1;  // Idle high
        bit_cnt_d = '0;
        if (fifo_mode ? ~fifo_empty : thr_full_q) begin
          tsr_d    = load_char;
          fifo_pop = fifo_mode;
          thr_load = ~fifo_mode;
          state_d  = TXSTART;
        end
      end
      TXSTART: begin
        if (baud_edge) begin
          txd_d   = 1'b0;  // Start bit
          state_d = TXDATA;
        end
      end
      TXDATA: begin
        if (baud_edge) begin
          txd_d     = tsr_q[bit_cnt_q];  // LSB first
          bit_cnt_d = bit_cnt_q + 3'd1;
          if (bit_cnt_q == last_bit) begin
            state_d = reg_read_i.lcr.par_en ? TXPAR : TXSTOP1;
          end
        end
      end
      TXPAR: begin
        if (baud_edge) begin
          txd_d   = par_bit;
          state_d = TXSTOP1;
        end
      end
      TXSTOP1: begin
        if (baud_edge) begin
          txd_d   = 1'b1;
          state_d = reg_read_i.lcr.stop_bits ? TXSTOP2 : TXIDLE;
        end
      end
      TXSTOP2: begin
        if (baud_edge) state_d = TXFINISH;
      end
      TXFINISH: begin
        // Extra half bit only for 5-bit words
        if ((reg_read_i.lcr.word_len != 2'b00) || double_baud_rate_i) state_d = TXIDLE;
      end
      default: state_d = TXIDLE;
    endcase
  end

  assign txd_o = txd_q & ~reg_read_i.lcr.set_break;  // Break pulls low

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      baud_q     <= 1'b0;
      thr_full_q <= 1'b0;
      thr_idle_q <= 1'b1;  // Matches LSR reset
      tx_idle_q  <= 1'b1;
      state_q    <= TXIDLE;
      bit_cnt_q  <= '0;
      txd_q      <= 1'b1;
    end else begin
      baud_q     <= baud_rate_i;
      thr_full_q <= thr_full_d;
      thr_idle_q <= thr_idle;
      tx_idle_q  <= tx_idle;
      state_q    <= state_d;
      bit_cnt_q  <= bit_cnt_d;
      txd_q      <= txd_d;
    end
  end

  always_ff @(posedge clk_i) begin
    tsr_q <= tsr_d;  // Shift data
  end

endmodule

//--- verilog/uart_top.sv
module uart_top #(
  parameter int unsigned TX_FIFO_DEPTH = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                reg_we_i,
  input  uart_pkg::reg_addr_t reg_addr_i,
  input  uart_pkg::char_t     reg_wdata_i,
  output uart_pkg::char_t     reg_rdata_o,
  output logic                txd_o
);

  import uart_pkg::*;

  reg_read_t     reg_read;          // Register snapshot to TX
  tx_reg_write_t reg_write;         // Status updates from TX
  divisor_t      divisor;
  logic          baud_rate;         // Bit-rate square wave
  logic          double_baud_rate;  // Half-bit pulse

  ////////////////////
  // Register file
  ////////////////////

  uart_regs i_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_write_i (reg_write),
    .reg_read_o  (reg_read),
    .divisor_o   (divisor)
  );

  uart_baud_gen i_baud_gen (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .divisor_i          (divisor),
    .baud_rate_o        (baud_rate),
    .double_baud_rate_o (double_baud_rate)
  );

  ////////////////////
  // Transmitter
  ////////////////////

  uart_tx #(
    .TX_FIFO_DEPTH (TX_FIFO_DEPTH)
  ) i_tx (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .baud_rate_i        (baud_rate),
    .double_baud_rate_i (double_baud_rate),
    .reg_read_i         (reg_read),
    .reg_write_o        (reg_write),
    .txd_o              (txd_o)
  );

endmodule

//--- tests/uart_tx_assert.sv
module uart_tx_assert #(
  parameter int unsigned DEPTH = 16
) (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input uart_pkg::state_type_tx  state_i,
  input logic                    txd_i,
  input uart_pkg::reg_read_t     reg_read_i,
  input uart_pkg::tx_reg_write_t reg_write_i,
  input logic                    fifo_push_i,
  input logic [$clog2(DEPTH):0]  fifo_usage_i
);

  import uart_pkg::*;

  int   fail_cnt = 0;  // Failed assertions so far
  logic thr_empty_q;   // Last thr_empty value sent to LSR

  // Shadow of the LSR thr_empty bit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      thr_empty_q <= 1'b1;  // LSR reset value
    end else if (reg_write_i.lsr_valid[0]) begin
      thr_empty_q <= reg_write_i.lsr_thr_empty;
    end
  end

  // Idle line is a mark unless break holds it low
  idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_i == TXIDLE && !reg_read_i.lcr.set_break) |-> txd_i)
    else begin
      fail_cnt++;
      $error("txd low in TXIDLE with no break set");
    end

  // tx_empty only rises once thr_empty is set
  lsr_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (reg_write_i.lsr_valid[1] && reg_write_i.lsr_tx_empty) |->
      (reg_write_i.lsr_valid[0] ? reg_write_i.lsr_thr_empty : thr_empty_q))
    else begin
      fail_cnt++;
      $error("tx_empty written as 1 with thr_empty written as 0");
    end

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_push_i |-> (fifo_usage_i < DEPTH))
    else begin
      fail_cnt++;
      $error("transmit FIFO pushed while full");
    end

endmodule

// Attached to every transmitter
bind uart_tx uart_tx_assert #(
  .DEPTH (TX_FIFO_DEPTH)
) i_tx_assert (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .state_i      (state_q),
  .txd_i        (txd_o),
  .reg_read_i   (reg_read_i),
  .reg_write_i  (reg_write_o),
  .fifo_push_i  (fifo_push),
  .fifo_usage_i (i_tx_fifo.usage_o)
);

//--- tests/uart_tb.sv
module uart_tb;

  import uart_pkg::*;

  localparam time         CLK_PERIOD = 100;
  localparam divisor_t    DIV        = 16'd8;
  localparam int unsigned NUM_FRAMES = 40;  // All frames of all tests
  localparam time         TIMEOUT    = NUM_FRAMES * 12 * DIV * CLK_PERIOD + 5000 * CLK_PERIOD;

  logic      clk;
  logic      rst_n;
  logic      reg_we;
  reg_addr_t reg_addr;
  char_t     reg_wdata;
  char_t     reg_rdata;
  logic      txd;

  divisor_t  div_cfg;  // Mirrors of the programmed registers
  lcr_t      lcr_cfg;
  int        checks;
  int        errors;

  uart_top #(
    .TX_FIFO_DEPTH (16)
  ) i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .reg_we_i    (reg_we),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .txd_o       (txd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("ERROR: watchdog expired at %0t, the tests did not finish", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////
  // Compare tasks
  //////////////////////

  task automatic check_char(input string name, input char_t got, input char_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_lsr(input string name, input lsr_t got, input lsr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  //////////////////////
  // Reference rules
  //////////////////////

  function automatic char_t char_mask(input logic [1:0] word_len);
    int nbits;
    nbits = int'(word_len) + 5;
    return char_t'((1 << nbits) - 1);
  endfunction

  function automatic logic expected_parity(input char_t data, input logic [1:0] sel);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += int'(data[i]);
    case (sel)
      2'b00:   return (ones % 2) == 0;  // Odd, total count of ones is odd
      2'b01:   return (ones % 2) == 1;  // Even
      2'b10:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  //////////////////////
  // Register port
  //////////////////////

  task automatic reg_write(input reg_addr_t addr, input char_t data);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_we    <= 1'b0;  // One cycle strobe
  endtask

  task automatic reg_read(input reg_addr_t addr, output char_t data);
    @(posedge clk);
    reg_addr <= addr;
    @(negedge clk);  // Read path is combinational
    data = reg_rdata;
  endtask

  task automatic wait_tx_idle();
    lsr_t rd;
    int   polls;
    polls = 0;
    reg_read(ADDR_LSR, rd);
    while (!rd.tx_empty && polls < 40 * int'(div_cfg)) begin
      polls++;
      reg_read(ADDR_LSR, rd);
    end
    if (!rd.tx_empty) begin
      errors++;
      $display("ERROR at %0t: transmitter never reported tx_empty", $time);
    end
  endtask

  task automatic set_divisor(input divisor_t div);
    reg_write(ADDR_DLL, div[7:0]);
    reg_write(ADDR_DLM, div[15:8]);
    div_cfg = div;
  endtask

  task automatic set_line(input lcr_t lcr);
    wait_tx_idle();  // Never reframe a character in flight
    reg_write(ADDR_LCR, lcr);
    lcr_cfg = lcr;
  endtask

  //////////////////////
  // Serial monitor
  //////////////////////

  // Samples mid-bit, offset off the clock edges
  task automatic recv_frame(output char_t data, output logic par, output time t_start);
    time bit_t;
    int  nbits;
    bit_t = div_cfg * CLK_PERIOD;
    nbits = int'(lcr_cfg.word_len) + 5;
    data  = '0;
    par   = 1'bx;
    @(negedge txd);
    t_start = $time;
    #(bit_t / 2 + CLK_PERIOD / 4);
    check_bit("txd start bit", txd, 1'b0);
    for (int i = 0; i < nbits; i++) begin
      #(bit_t);
      data[i] = txd;  // LSB first
    end
    if (lcr_cfg.par_en) begin
      #(bit_t);
      par = txd;
    end
    #(bit_t);
    check_bit("txd stop bit 1", txd, 1'b1);
    // Half stop of 5-bit words is measured by the caller
    if (lcr_cfg.stop_bits && lcr_cfg.word_len != 2'd0) begin
      #(bit_t);
      check_bit("txd stop bit 2", txd, 1'b1);
    end
  endtask

  task automatic send_char(input char_t c, output char_t got, output logic par);
    time t0;
    fork
      reg_write(ADDR_THR, c);
      recv_frame(got, par, t0);
    join
  endtask

  task automatic hold_level(input string name, input logic level, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_bit(name, txd, level);
    end
  endtask

  //////////////////////
  // Tests
  //////////////////////

  task automatic basic_8n1();
    char_t c, got, rd;
    logic  par;
    time   t0;
    set_line(LCR_RESET);
    repeat (4) begin
      c = char_t'($urandom);
      fork
        begin
          reg_write(ADDR_THR, c);
          reg_read(ADDR_LSR, rd);
          check_lsr("lsr after write", rd, 8'h00);
        end
        recv_frame(got, par, t0);
      join
      check_char("8n1 data", got, c);
      reg_read(ADDR_LSR, rd);
      check_lsr("lsr after frame", rd, LSR_RESET);
    end
  endtask

  task automatic short_words();
    lcr_t  l;
    char_t c, got;
    logic  par;
    for (int wl = 0; wl < 3; wl++) begin
      l          = '0;
      l.word_len = wl[1:0];
      set_line(l);
      repeat (2) begin
        c = char_t'($urandom);
        send_char(c, got, par);
        check_char("short word data", got, c & char_mask(l.word_len));
      end
    end
  endtask

  task automatic parity_modes();
    lcr_t  l;
    char_t c, got, m;
    logic  par;
    for (int sel = 0; sel < 4; sel++) begin
      for (int wl = 2; wl < 4; wl++) begin
        l          = '0;
        l.word_len = wl[1:0];
        l.par_en   = 1'b1;
        l.par_sel  = sel[1:0];
        set_line(l);
        c = char_t'($urandom);
        m = c & char_mask(l.word_len);
        send_char(c, got, par);
        check_char("parity frame data", got, m);
        check_bit("parity bit", par, expected_parity(m, l.par_sel));
      end
    end
  endtask

  // Two frames back to back, line high from stop start to next start
  task automatic stop_timing(input logic [1:0] word_len, input time min_high,
                             input time max_high);
    lcr_t  l;
    char_t a, b, g1, g2;
    logic  par;
    time   t1, t2, high;
    l           = '0;
    l.word_len  = word_len;
    l.stop_bits = 1'b1;
    set_line(l);
    a = char_t'($urandom);
    b = char_t'($urandom);
    fork
      begin
        reg_write(ADDR_THR, a);
        reg_write(ADDR_THR, b);  // Waits in THR behind the first
      end
      begin
        recv_frame(g1, par, t1);
        recv_frame(g2, par, t2);
      end
    join
    check_char("stop test first", g1, a & char_mask(word_len));
    check_char("stop test second", g2, b & char_mask(word_len));
    high = t2 - (t1 + (int'(word_len) + 6) * div_cfg * CLK_PERIOD);
    checks++;
    if (high < min_high || high > max_high) begin
      errors++;
      $display("ERROR at %0t: stop interval of %0t is outside %0t to %0t",
               $time, high, min_high, max_high);
    end
  endtask

  task automatic fifo_burst();
    char_t burst[17];
    char_t got, rd;
    logic  par;
    time   t0;
    set_line(LCR_RESET);
    reg_write(ADDR_FCR, 8'h01);
    foreach (burst[i]) burst[i] = char_t'($urandom);
    fork
      foreach (burst[i]) reg_write(ADDR_THR, burst[i]);
      foreach (burst[i]) begin
        recv_frame(got, par, t0);
        check_char("fifo burst data", got, burst[i]);
      end
    join
    wait_tx_idle();
    // Reset the FIFO with characters still queued
    fork
      begin
        for (int i = 0; i < 6; i++) reg_write(ADDR_THR, burst[i]);
        reg_write(ADDR_FCR, 8'h05);
      end
      begin
        recv_frame(got, par, t0);
        check_char("frame across fifo reset", got, burst[0]);
      end
    join
    reg_read(ADDR_FCR, rd);
    check_char("fcr after fifo reset", rd, 8'h01);
    hold_level("txd after fifo reset", 1'b1, 3 * int'(div_cfg));
    reg_read(ADDR_LSR, rd);
    check_lsr("lsr after fifo reset", rd, LSR_RESET);
    reg_write(ADDR_FCR, 8'h00);
  endtask

  task automatic break_control();
    lcr_t l;
    l           = LCR_RESET;
    l.set_break = 1'b1;
    set_line(l);
    hold_level("txd during break", 1'b0, 3 * int'(div_cfg));
    set_line(LCR_RESET);
    hold_level("txd after break", 1'b1, 4);
  endtask

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    char_t rd;
    void'($urandom(32'h505a1fd2));
    rst_n     = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    div_cfg   = 16'd1;
    lcr_cfg   = LCR_RESET;
    checks    = 0;
    errors    = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // Reset state
    reg_read(ADDR_LSR, rd);
    check_lsr("lsr reset", rd, LSR_RESET);
    reg_read(ADDR_LCR, rd);
    check_char("lcr reset", rd, LCR_RESET);
    reg_read(ADDR_DLL, rd);
    check_char("dll reset", rd, 8'h01);
    check_bit("txd reset", txd, 1'b1);
    set_divisor(DIV);
    basic_8n1();
    short_words();
    parity_modes();
    stop_timing(2'd3, 2 * DIV * CLK_PERIOD, 2 * DIV * CLK_PERIOD);
    stop_timing(2'd0, 3 * DIV * CLK_PERIOD / 2, 2 * DIV * CLK_PERIOD);  // 1.5 stop bits
    fifo_burst();
    break_control();
    errors += i_dut.i_tx.i_tx_assert.fail_cnt;  // Bound checker failures
    $display("uart_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/uart_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_regs.sv
verilog/uart_tx_fifo.sv
verilog/uart_tx.sv
verilog/uart_top.sv
tests/uart_tx_assert.sv
tests/uart_tb.sv
